// ==== filelist.f ====
verilog/fetchPkg.sv
verilog/branchTargetBuffer.sv
verilog/branchPredictor.sv
verilog/returnAddrStack.sv
verilog/instCache.sv
verilog/fetchStage1.sv
dv/fetchStage1Tb.sv

// ==== dv/fetchStage1Tb.sv ====
`timescale 1ns/1ps

module fetchStage1Tb
  import fetchPkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 4;
  localparam int DIRECTED_CYCLES = 120;
  localparam int RANDOM_CYCLES   = 300;
  localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
  // table sizes match the default parameters of the DUT.
  localparam int BTB_N  = 16;
  localparam int BP_N   = 64;
  localparam int RAS_N  = 8;
  localparam int LINE_N = 16;

  logic                            clk;
  logic                            reset;
  logic                            stall_i;
  logic                            recoverFlag_i;
  logic [PC_WIDTH-1:0]             recoverPC_i;
  logic                            exceptionFlag_i;
  logic [PC_WIDTH-1:0]             exceptionPC_i;
  logic                            flagRecoverID_i;
  logic [PC_WIDTH-1:0]             targetAddrID_i;
  logic                            flagRecoverEX_i;
  logic [PC_WIDTH-1:0]             targetAddrEX_i;
  logic [PC_WIDTH-1:0]             updatePC_i;
  logic [PC_WIDTH-1:0]             updateTargetAddr_i;
  logic [BR_TYPE_WIDTH-1:0]        updateBrType_i;
  logic                            updateDir_i;
  logic                            updateEn_i;
  logic                            wrEnable_i;
  logic [PC_WIDTH-1:0]             wrAddr_i;
  logic [BUNDLE_WIDTH-1:0]         instBlock_i;
  logic                            fs1Ready_o;
  logic [BUNDLE_WIDTH-1:0]         instructionBundle_o;
  logic [PC_WIDTH-1:0]             pc_o;
  logic [FETCH_WIDTH-1:0]          btbHit_o;
  logic [FETCH_WIDTH*PC_WIDTH-1:0] targetAddr_o;
  logic [FETCH_WIDTH-1:0]          prediction_o;
  logic                            miss_o;
  logic [PC_WIDTH-1:0]             missAddr_o;

  // the model keeps full slot and line addresses instead of split tags.
  logic                     btbValid  [BTB_N];
  logic [PC_WIDTH-1:0]      btbPc     [BTB_N];
  logic [BR_TYPE_WIDTH-1:0] btbType   [BTB_N];
  logic [PC_WIDTH-1:0]      btbTarget [BTB_N];
  logic [1:0]               counter   [BP_N];
  logic [PC_WIDTH-1:0]      ras       [RAS_N];
  int                       rasPtr;
  logic                     lineValid [LINE_N];
  logic [PC_WIDTH-1:0]      lineAddr  [LINE_N];
  logic [BUNDLE_WIDTH-1:0]  lineData  [LINE_N];
  logic [PC_WIDTH-1:0]      modelPc;
  logic [31:0]              rngState = 32'h760f_683a;
  string                    testName = "reset_refill";

  fetchStage1 u_dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic logic [BUNDLE_WIDTH-1:0] randBundle();
    logic [BUNDLE_WIDTH-1:0] b;
    for (int w = 0; w < BUNDLE_WIDTH / 32; w++) begin
      b[w*32 +: 32] = nextRand();
    end
    return b;
  endfunction

  function automatic int btbIndex(logic [PC_WIDTH-1:0] a);
    return int'((a / SLOT_BYTES) % BTB_N);
  endfunction

  function automatic int lineIndex(logic [PC_WIDTH-1:0] a);
    return int'((a / BUNDLE_BYTES) % LINE_N);
  endfunction

  function automatic logic [PC_WIDTH-1:0] slotPc(int s);
    return modelPc + PC_WIDTH'(s * SLOT_BYTES);
  endfunction

  function automatic logic slotHit(int s);
    return btbValid[btbIndex(slotPc(s))] && (btbPc[btbIndex(slotPc(s))] == slotPc(s));
  endfunction

  // a counter of 10 or 11 predicts taken.
  function automatic logic slotPred(int s);
    return counter[int'((slotPc(s) / SLOT_BYTES) % BP_N)] >= 2'b10;
  endfunction

  function automatic logic [BR_TYPE_WIDTH-1:0] slotType(int s);
    return btbType[btbIndex(slotPc(s))];
  endfunction

  function automatic logic slotTaken(int s);
    return slotHit(s) && (slotPred(s) || (slotType(s) != BR_COND));
  endfunction

  // returns read the top of the stack, which is the entry below the pointer.
  function automatic logic [PC_WIDTH-1:0] slotTarget(int s);
    if (slotType(s) == BR_RETURN) begin
      return ras[(rasPtr + RAS_N - 1) % RAS_N];
    end
    return btbTarget[btbIndex(slotPc(s))];
  endfunction

  function automatic logic lineHit();
    return lineValid[lineIndex(modelPc)] && (lineAddr[lineIndex(modelPc)] == modelPc);
  endfunction

  // expected {push, pop, push address, next PC} for the current state and inputs.
  function automatic logic [2*PC_WIDTH+1:0] refNext();
    int                  taken;
    logic                push;
    logic                pop;
    logic [PC_WIDTH-1:0] pushAddr;
    logic [PC_WIDTH-1:0] next;
    taken    = -1;
    push     = 1'b0;
    pop      = 1'b0;
    pushAddr = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if ((taken < 0) && slotTaken(s)) begin
        taken = s;
      end
    end
    if (recoverFlag_i) begin
      next = recoverPC_i;
    end else if (exceptionFlag_i) begin
      next = exceptionPC_i;
    end else if (stall_i || !lineHit()) begin
      next = modelPc;
    end else if (flagRecoverEX_i) begin
      next = targetAddrEX_i;
    end else if (flagRecoverID_i) begin
      next = targetAddrID_i;
    end else if (taken >= 0) begin
      // only a slot that actually supplies the next PC touches the stack.
      next     = slotTarget(taken);
      push     = (slotType(taken) == BR_CALL);
      pop      = (slotType(taken) == BR_RETURN);
      pushAddr = slotPc(taken) + PC_WIDTH'(SLOT_BYTES);
    end else begin
      next = modelPc + PC_WIDTH'(BUNDLE_BYTES);
    end
    return {push, pop, pushAddr, next};
  endfunction

  task automatic checkPc(string what, logic [PC_WIDTH-1:0] expected,
                         logic [PC_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic checkFlag(string what, logic expected, logic actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %b, actual %b", testName, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic checkBundle(string what, logic [BUNDLE_WIDTH-1:0] expected,
                             logic [BUNDLE_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic checkSlotBits(string what, logic [FETCH_WIDTH-1:0] expected,
                               logic [FETCH_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %b, actual %b", testName, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic checkTarget(int slot, logic [PC_WIDTH-1:0] expected,
                             logic [PC_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s targetAddr_o slot %0d: expected %h, actual %h",
               testName, slot, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic resetModel();
    modelPc = RESET_PC;
    rasPtr  = 0;
    for (int e = 0; e < BTB_N; e++) begin
      btbValid[e] = 1'b0;
    end
    for (int e = 0; e < BP_N; e++) begin
      counter[e] = 2'b01;
    end
    for (int e = 0; e < RAS_N; e++) begin
      ras[e] = '0;
    end
    for (int e = 0; e < LINE_N; e++) begin
      lineValid[e] = 1'b0;
    end
  endtask

  task automatic checkOutputs();
    logic [FETCH_WIDTH-1:0] hits;
    logic [FETCH_WIDTH-1:0] preds;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      hits[s]  = slotHit(s);
      preds[s] = slotPred(s);
    end
    checkPc("pc_o", modelPc, pc_o);
    checkFlag("miss_o", !lineHit(), miss_o);
    checkFlag("fs1Ready_o", lineHit(), fs1Ready_o);
    checkPc("missAddr_o", modelPc & ~PC_WIDTH'(BUNDLE_BYTES - 1), missAddr_o);
    // the bundle is only meaningful when the line is present.
    if (lineHit()) begin
      checkBundle("instructionBundle_o", lineData[lineIndex(modelPc)], instructionBundle_o);
    end
    checkSlotBits("btbHit_o", hits, btbHit_o);
    checkSlotBits("prediction_o", preds, prediction_o);
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if (hits[s]) begin
        checkTarget(s, slotTarget(s), targetAddr_o[s*PC_WIDTH +: PC_WIDTH]);
      end
    end
  endtask

  // applies what the next rising edge does to the PC, the stack and every table.
  task automatic advanceModel();
    logic [2*PC_WIDTH+1:0] nxt;
    int                    i;
    nxt = refNext();
    if (nxt[2*PC_WIDTH+1]) begin
      ras[rasPtr] = nxt[2*PC_WIDTH-1:PC_WIDTH];
      rasPtr      = (rasPtr + 1) % RAS_N;
    end else if (nxt[2*PC_WIDTH]) begin
      rasPtr = (rasPtr + RAS_N - 1) % RAS_N;
    end
    modelPc = nxt[PC_WIDTH-1:0];
    // a not-taken conditional branch never enters the BTB.
    if (updateEn_i && ((updateBrType_i != BR_COND) || updateDir_i)) begin
      i            = btbIndex(updatePC_i);
      btbValid[i]  = 1'b1;
      btbPc[i]     = updatePC_i;
      btbType[i]   = updateBrType_i;
      btbTarget[i] = updateTargetAddr_i & ~PC_WIDTH'(BUNDLE_BYTES - 1);
    end
    if (updateEn_i && (updateBrType_i == BR_COND)) begin
      i = int'((updatePC_i / SLOT_BYTES) % BP_N);
      if (updateDir_i && (counter[i] != 2'b11)) begin
        counter[i] = counter[i] + 2'd1;
      end else if (!updateDir_i && (counter[i] != 2'b00)) begin
        counter[i] = counter[i] - 2'd1;
      end
    end
    if (wrEnable_i) begin
      i            = lineIndex(wrAddr_i);
      lineValid[i] = 1'b1;
      lineAddr[i]  = wrAddr_i & ~PC_WIDTH'(BUNDLE_BYTES - 1);
      lineData[i]  = instBlock_i;
    end
  endtask

  // inputs change only after rising edges, so the falling edge sees settled values.
  // the model stays in its reset state until reset is known to be released.
  always @(negedge clk) begin
    if (reset !== 1'b0) begin
      resetModel();
    end else begin
      checkOutputs();
      advanceModel();
    end
  end

  task automatic clearStrobes();
    recoverFlag_i   <= 1'b0;
    exceptionFlag_i <= 1'b0;
    flagRecoverEX_i <= 1'b0;
    flagRecoverID_i <= 1'b0;
    updateEn_i      <= 1'b0;
    wrEnable_i      <= 1'b0;
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      clearStrobes();
    end
  endtask

  task automatic setStall(logic level);
    @(posedge clk);
    clearStrobes();
    stall_i <= level;
  endtask

  task automatic putBranch(logic [PC_WIDTH-1:0] pc, logic [BR_TYPE_WIDTH-1:0] brType,
                           logic [PC_WIDTH-1:0] target, logic dir);
    @(posedge clk);
    clearStrobes();
    updateEn_i         <= 1'b1;
    updatePC_i         <= pc;
    updateBrType_i     <= brType;
    updateTargetAddr_i <= target;
    updateDir_i        <= dir;
  endtask

  task automatic refill(logic [PC_WIDTH-1:0] addr, logic [BUNDLE_WIDTH-1:0] data);
    @(posedge clk);
    clearStrobes();
    wrEnable_i  <= 1'b1;
    wrAddr_i    <= addr;
    instBlock_i <= data;
  endtask

  task automatic redirectTo(logic [PC_WIDTH-1:0] addr);
    @(posedge clk);
    clearStrobes();
    recoverFlag_i <= 1'b1;
    recoverPC_i   <= addr;
  endtask

  initial begin
    int                       order [LINE_N];
    int                       j;
    int                       tmp;
    logic [31:0]              r;
    logic [PC_WIDTH-1:0]      updPc;
    logic [BR_TYPE_WIDTH-1:0] updType;
    logic [5:0]               dirSeq;
    reset              = 1'b1;
    stall_i            = 1'b0;
    recoverFlag_i      = 1'b0;
    recoverPC_i        = '0;
    exceptionFlag_i    = 1'b0;
    exceptionPC_i      = '0;
    flagRecoverID_i    = 1'b0;
    targetAddrID_i     = '0;
    flagRecoverEX_i    = 1'b0;
    targetAddrEX_i     = '0;
    updatePC_i         = '0;
    updateTargetAddr_i = '0;
    updateBrType_i     = BR_JUMP;
    updateDir_i        = 1'b0;
    updateEn_i         = 1'b0;
    wrEnable_i         = 1'b0;
    wrAddr_i           = '0;
    instBlock_i        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // the PC waits on the missing line 0, then each later line arrives in shuffled order.
    idle(3);
    refill(RESET_PC, randBundle());
    idle(2);
    for (int i = 0; i < LINE_N; i++) begin
      order[i] = i;
    end
    for (int i = LINE_N - 1; i > 1; i--) begin
      j        = 1 + int'(nextRand() % i);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 1; i < LINE_N; i++) begin
      refill(PC_WIDTH'(order[i] * BUNDLE_BYTES), randBundle());
      idle(1);
    end

    testName = "stall_hold";
    redirectTo(32'h40);
    setStall(1'b1);
    putBranch(32'h48, BR_JUMP, 32'h100, 1'b1);
    idle(3);
    setStall(1'b0);
    idle(3);

    // first a jump in slot 2 alone, then a second one in slot 1 that must win.
    testName = "jump_priority";
    putBranch(32'h1d0, BR_JUMP, 32'h80, 1'b1);
    redirectTo(32'h1c0);
    idle(3);
    putBranch(32'h1c8, BR_JUMP, 32'h140, 1'b1);
    redirectTo(32'h1c0);
    idle(3);

    // the counter walks 00, 01, 10, 11, 10, 01 with the bit sequence below.
    testName = "cond_counter";
    dirSeq   = 6'b001110;
    for (int i = 0; i < 6; i++) begin
      putBranch(32'h180, BR_COND, 32'h20, dirSeq[i]);
      redirectTo(32'h180);
      idle(2);
    end

    // nested calls sit in slot 3 so that each return address starts a bundle.
    testName = "call_return";
    setStall(1'b1);
    putBranch(32'h98, BR_CALL, 32'hc0, 1'b1);
    putBranch(32'hd8, BR_CALL, 32'h100, 1'b1);
    putBranch(32'h108, BR_RETURN, 32'h0, 1'b1);
    putBranch(32'he8, BR_RETURN, 32'h0, 1'b1);
    redirectTo(32'h80);
    idle(3);
    setStall(1'b0);
    idle(8);

    testName = "redirect_random";
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      r       = nextRand();
      updType = r[17:16];
      updPc   = nextRand() & 32'h1f8;
      if (updType == BR_CALL) begin
        updPc = updPc | 32'h18;
      end
      @(posedge clk);
      stall_i            <= (r[2:0] == 3'b000);
      recoverFlag_i      <= (r[5:3] == 3'b000);
      recoverPC_i        <= nextRand() & 32'h1e0;
      exceptionFlag_i    <= (r[8:6] == 3'b000);
      exceptionPC_i      <= nextRand() & 32'h1e0;
      flagRecoverEX_i    <= (r[10:9] == 2'b00);
      targetAddrEX_i     <= nextRand() & 32'h1e0;
      flagRecoverID_i    <= (r[12:11] == 2'b00);
      targetAddrID_i     <= nextRand() & 32'h1e0;
      updateEn_i         <= r[13];
      updateDir_i        <= r[14];
      updatePC_i         <= updPc;
      updateBrType_i     <= updType;
      updateTargetAddr_i <= nextRand() & 32'h1ff;
      wrEnable_i         <= (r[21:18] == 4'b0000);
      wrAddr_i           <= nextRand() & 32'h1e0;
      instBlock_i        <= randBundle();
    end
    setStall(1'b0);
    idle(2);
    $display("Simulation passed");
    $finish;
  end

  // the limit is twice the total stimulus length.
  initial begin
    #(2 * STIM_CYCLES * CLK_PERIOD);
    $display("Watchdog expired: the tests did not finish within %0d cycles", 2 * STIM_CYCLES);
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

// ==== verilog/fetchStage1.sv ====
`timescale 1ns/1ps

module fetchStage1
  import fetchPkg::*;
#(
  parameter int BTB_ENTRIES = 16,
  parameter int BP_ENTRIES  = 64,
  parameter int RAS_DEPTH   = 8,
  parameter int CACHE_LINES = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            stall_i,
  input  logic                            recoverFlag_i,
  input  logic [PC_WIDTH-1:0]             recoverPC_i,
  input  logic                            exceptionFlag_i,
  input  logic [PC_WIDTH-1:0]             exceptionPC_i,
  input  logic                            flagRecoverID_i,
  input  logic [PC_WIDTH-1:0]             targetAddrID_i,
  input  logic                            flagRecoverEX_i,
  input  logic [PC_WIDTH-1:0]             targetAddrEX_i,
  input  logic [PC_WIDTH-1:0]             updatePC_i,
  input  logic [PC_WIDTH-1:0]             updateTargetAddr_i,
  input  logic [BR_TYPE_WIDTH-1:0]        updateBrType_i,
  input  logic                            updateDir_i,
  input  logic                            updateEn_i,
  input  logic                            wrEnable_i,
  input  logic [PC_WIDTH-1:0]             wrAddr_i,
  input  logic [BUNDLE_WIDTH-1:0]         instBlock_i,
  output logic                            fs1Ready_o,
  output logic [BUNDLE_WIDTH-1:0]         instructionBundle_o,
  output logic [PC_WIDTH-1:0]             pc_o,
  output logic [FETCH_WIDTH-1:0]          btbHit_o,
  output logic [FETCH_WIDTH*PC_WIDTH-1:0] targetAddr_o,
  output logic [FETCH_WIDTH-1:0]          prediction_o,
  output logic                            miss_o,
  output logic [PC_WIDTH-1:0]             missAddr_o
);

  localparam int SLOT_IDX_BITS = $clog2(FETCH_WIDTH);

  logic [PC_WIDTH-1:0]                  pc;
  logic [PC_WIDTH-1:0]                  nextPc;
  logic                                 cacheMiss;
  logic                                 updateBtbEn;
  logic                                 updateBpEn;
  logic [FETCH_WIDTH-1:0]               btbHit;
  logic [FETCH_WIDTH*BR_TYPE_WIDTH-1:0] btbType;
  logic [FETCH_WIDTH*PC_WIDTH-1:0]      btbTarget;
  logic [FETCH_WIDTH-1:0]               prediction;
  logic [PC_WIDTH-1:0]                  rasTop;
  logic [FETCH_WIDTH-1:0]               slotTaken;
  logic [BR_TYPE_WIDTH-1:0]             slotType   [FETCH_WIDTH];
  logic [PC_WIDTH-1:0]                  slotAddr   [FETCH_WIDTH];
  logic [PC_WIDTH-1:0]                  slotTarget [FETCH_WIDTH];
  logic                                 takenAny;
  logic [SLOT_IDX_BITS-1:0]             takenSlot;
  logic                                 pcAdvance;
  logic                                 predUsed;
  logic                                 rasPush;
  logic                                 rasPop;
  logic [PC_WIDTH-1:0]                  rasPushAddr;

  // only conditional branches train the counters. a not-taken one leaves the BTB alone.
  assign updateBpEn  = updateEn_i && (updateBrType_i == BR_COND);
  assign updateBtbEn = updateEn_i && !((updateBrType_i == BR_COND) && !updateDir_i);

  branchTargetBuffer #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
    .clk(clk), .reset(reset), .pc_i(pc), .updateEn_i(updateBtbEn),
    .updatePC_i(updatePC_i), .updateBrType_i(updateBrType_i),
    .updateTargetAddr_i(updateTargetAddr_i),
    .btbHit_o(btbHit), .ctrlType_o(btbType), .targetAddr_o(btbTarget)
  );

  branchPredictor #(.BP_ENTRIES(BP_ENTRIES)) u_bp (
    .clk(clk), .reset(reset), .pc_i(pc), .updateEn_i(updateBpEn),
    .updatePC_i(updatePC_i), .updateDir_i(updateDir_i), .prediction_o(prediction)
  );

  returnAddrStack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
    .clk(clk), .reset(reset), .push_i(rasPush), .pop_i(rasPop),
    .pushAddr_i(rasPushAddr), .addrRAS_o(rasTop)
  );

  instCache #(.CACHE_LINES(CACHE_LINES)) u_icache (
    .clk(clk), .reset(reset), .addr_i(pc), .wrEnable_i(wrEnable_i), .wrAddr_i(wrAddr_i),
    .instBlock_i(instBlock_i), .instBundle_o(instructionBundle_o), .miss_o(cacheMiss),
    .missAddr_o(missAddr_o)
  );

  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : gSlot
    assign slotType[s] = btbType[s*BR_TYPE_WIDTH +: BR_TYPE_WIDTH];
    assign slotAddr[s] = pc + PC_WIDTH'(s * SLOT_BYTES);
    // unconditional control flow redirects on any hit, a branch needs a taken prediction.
    assign slotTaken[s] = btbHit[s] && (prediction[s] || (slotType[s] != BR_COND));
    // returns take their target from the stack instead of the BTB.
    assign slotTarget[s] = (slotType[s] == BR_RETURN) ? rasTop : btbTarget[s*PC_WIDTH +: PC_WIDTH];
    assign targetAddr_o[s*PC_WIDTH +: PC_WIDTH] = slotTarget[s];
  end

  // scan downwards so that the lowest taken slot is the one left standing.
  always_comb begin
    takenAny  = 1'b0;
    takenSlot = '0;
    for (int s = FETCH_WIDTH - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        takenAny  = 1'b1;
        takenSlot = SLOT_IDX_BITS'(s);
      end
    end
  end

  // later stages outrank the prediction of this stage.
  assign predUsed = takenAny && !flagRecoverEX_i && !flagRecoverID_i;
  assign nextPc   = flagRecoverEX_i ? targetAddrEX_i :
                    flagRecoverID_i ? targetAddrID_i :
                    takenAny        ? slotTarget[takenSlot] :
                    pc + PC_WIDTH'(BUNDLE_BYTES);

  // the stack moves only together with a normal PC advance.
  assign pcAdvance   = !recoverFlag_i && !exceptionFlag_i && !stall_i && !cacheMiss;
  assign rasPush     = pcAdvance && predUsed && (slotType[takenSlot] == BR_CALL);
  assign rasPop      = pcAdvance && predUsed && (slotType[takenSlot] == BR_RETURN);
  assign rasPushAddr = slotAddr[takenSlot] + PC_WIDTH'(SLOT_BYTES);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (recoverFlag_i) begin
      pc <= recoverPC_i;
    end else if (exceptionFlag_i) begin
      pc <= exceptionPC_i;
    end else if (!stall_i && !cacheMiss) begin
      pc <= nextPc;
    end
  end

  assign pc_o         = pc;
  assign btbHit_o     = btbHit;
  assign prediction_o = prediction;
  assign miss_o       = cacheMiss;
  assign fs1Ready_o   = !cacheMiss;

  // every PC source, including the BTB and stack targets, must stay bundle aligned.
  pcBundleAligned: assert property (@(posedge clk) disable iff (reset)
    pc[OFFSET_BITS-1:0] == '0);

endmodule

// ==== verilog/instCache.sv ====
`timescale 1ns/1ps

module instCache
  import fetchPkg::*;
#(
  parameter int CACHE_LINES = 16
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [PC_WIDTH-1:0]     addr_i,
  input  logic                    wrEnable_i,
  input  logic [PC_WIDTH-1:0]     wrAddr_i,
  input  logic [BUNDLE_WIDTH-1:0] instBlock_i,
  output logic [BUNDLE_WIDTH-1:0] instBundle_o,
  output logic                    miss_o,
  output logic [PC_WIDTH-1:0]     missAddr_o
);

  // one line holds exactly one bundle, so the index starts right above the bundle offset.
  localparam int IDX_BITS = $clog2(CACHE_LINES);
  localparam int TAG_LSB  = OFFSET_BITS + IDX_BITS;
  localparam int TAG_BITS = PC_WIDTH - TAG_LSB;

  logic                    lineValid [CACHE_LINES];
  logic [TAG_BITS-1:0]     lineTag   [CACHE_LINES];
  logic [BUNDLE_WIDTH-1:0] lineData  [CACHE_LINES];
  logic [IDX_BITS-1:0]     rdIdx;
  logic [IDX_BITS-1:0]     wrIdx;
  logic                    tagHit;

  assign rdIdx = addr_i[OFFSET_BITS +: IDX_BITS];
  assign wrIdx = wrAddr_i[OFFSET_BITS +: IDX_BITS];

  // the lookup is purely combinational on the fetch address.
  assign tagHit       = lineValid[rdIdx] && (lineTag[rdIdx] == addr_i[PC_WIDTH-1:TAG_LSB]);
  assign instBundle_o = lineData[rdIdx];
  assign miss_o       = !tagHit;

  // the memory side always refills whole lines.
  assign missAddr_o = {addr_i[PC_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)};

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int l = 0; l < CACHE_LINES; l++) begin
        lineValid[l] <= 1'b0;
      end
    end else if (wrEnable_i) begin
      lineValid[wrIdx] <= 1'b1;
    end
  end

  // tag and data follow the valid bit on the same refill edge.
  always_ff @(posedge clk) begin
    if (wrEnable_i) begin
      lineTag[wrIdx]  <= wrAddr_i[PC_WIDTH-1:TAG_LSB];
      lineData[wrIdx] <= instBlock_i;
    end
  end

endmodule

// ==== verilog/returnAddrStack.sv ====
`timescale 1ns/1ps

module returnAddrStack
  import fetchPkg::*;
#(
  parameter int RAS_DEPTH = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                push_i,
  input  logic                pop_i,
  input  logic [PC_WIDTH-1:0] pushAddr_i,
  output logic [PC_WIDTH-1:0] addrRAS_o
);

  localparam int PTR_BITS = $clog2(RAS_DEPTH);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(RAS_DEPTH - 1);

  logic [PC_WIDTH-1:0] stack [RAS_DEPTH];
  // the pointer names the next free slot, so the top lives just below it.
  logic [PTR_BITS-1:0] ptr;
  logic [PTR_BITS-1:0] ptrUp;
  logic [PTR_BITS-1:0] ptrDown;

  // both neighbours wrap around the ends of the array.
  // an overflow simply overwrites the oldest return address.
  assign ptrUp   = (ptr == LAST_PTR) ? '0 : ptr + PTR_BITS'(1);
  assign ptrDown = (ptr == '0) ? LAST_PTR : ptr - PTR_BITS'(1);

  assign addrRAS_o = stack[ptrDown];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
      for (int e = 0; e < RAS_DEPTH; e++) begin
        stack[e] <= '0;
      end
    end else if (push_i) begin
      stack[ptr] <= pushAddr_i;
      ptr        <= ptrUp;
    end else if (pop_i) begin
      // a pop only moves the pointer, the old entry stays for a later push.
      ptr <= ptrDown;
    end
  end

  // fetch picks a single taken slot per bundle, which is either a call or a return.
  noPushWithPop: assert property (@(posedge clk) disable iff (reset)
    !(push_i && pop_i));

endmodule

// ==== verilog/branchPredictor.sv ====
`timescale 1ns/1ps

module branchPredictor
  import fetchPkg::*;
#(
  parameter int BP_ENTRIES = 64
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [PC_WIDTH-1:0]    pc_i,
  input  logic                   updateEn_i,
  input  logic [PC_WIDTH-1:0]    updatePC_i,
  input  logic                   updateDir_i,
  output logic [FETCH_WIDTH-1:0] prediction_o
);

  localparam int IDX_BITS = $clog2(BP_ENTRIES);

  // one 2-bit counter per entry, 00 strongly not taken up to 11 strongly taken.
  logic [1:0]          counter [BP_ENTRIES];
  logic [IDX_BITS-1:0] updateIdx;
  logic [1:0]          updateCnt;

  assign updateIdx = updatePC_i[SLOT_OFFSET_BITS +: IDX_BITS];
  assign updateCnt = counter[updateIdx];

  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : gSlot
    logic [PC_WIDTH-1:0] slotAddr;

    assign slotAddr = pc_i + PC_WIDTH'(s * SLOT_BYTES);
    // the upper counter bit is set for 10 and 11, which both mean taken.
    assign prediction_o[s] = counter[slotAddr[SLOT_OFFSET_BITS +: IDX_BITS]][1];
  end

  // counters start weakly not taken and saturate at both ends.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < BP_ENTRIES; e++) begin
        counter[e] <= 2'b01;
      end
    end else if (updateEn_i) begin
      if (updateDir_i && (updateCnt != 2'b11)) begin
        counter[updateIdx] <= updateCnt + 2'd1;
      end else if (!updateDir_i && (updateCnt != 2'b00)) begin
        counter[updateIdx] <= updateCnt - 2'd1;
      end
    end
  end

endmodule

// ==== verilog/branchTargetBuffer.sv ====
`timescale 1ns/1ps

module branchTargetBuffer
  import fetchPkg::*;
#(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [PC_WIDTH-1:0]                  pc_i,
  input  logic                                 updateEn_i,
  input  logic [PC_WIDTH-1:0]                  updatePC_i,
  input  logic [BR_TYPE_WIDTH-1:0]             updateBrType_i,
  input  logic [PC_WIDTH-1:0]                  updateTargetAddr_i,
  output logic [FETCH_WIDTH-1:0]               btbHit_o,
  output logic [FETCH_WIDTH*BR_TYPE_WIDTH-1:0] ctrlType_o,
  output logic [FETCH_WIDTH*PC_WIDTH-1:0]      targetAddr_o
);

  // the index sits right above the slot offset and the tag takes everything above it.
  localparam int IDX_BITS = $clog2(BTB_ENTRIES);
  localparam int TAG_LSB  = SLOT_OFFSET_BITS + IDX_BITS;
  localparam int TAG_BITS = PC_WIDTH - TAG_LSB;

  logic                     entryValid  [BTB_ENTRIES];
  logic [TAG_BITS-1:0]      entryTag    [BTB_ENTRIES];
  logic [BR_TYPE_WIDTH-1:0] entryType   [BTB_ENTRIES];
  logic [PC_WIDTH-1:0]      entryTarget [BTB_ENTRIES];
  logic [IDX_BITS-1:0]      updateIdx;

  assign updateIdx = updatePC_i[SLOT_OFFSET_BITS +: IDX_BITS];

  // four independent read ports serve the four slots of the bundle.
  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : gSlot
    logic [PC_WIDTH-1:0] slotAddr;
    logic [IDX_BITS-1:0] slotIdx;

    assign slotAddr = pc_i + PC_WIDTH'(s * SLOT_BYTES);
    assign slotIdx  = slotAddr[SLOT_OFFSET_BITS +: IDX_BITS];
    // a hit needs a valid entry whose tag matches the slot address.
    assign btbHit_o[s] = entryValid[slotIdx] &&
                         (entryTag[slotIdx] == slotAddr[PC_WIDTH-1:TAG_LSB]);
    assign ctrlType_o[s*BR_TYPE_WIDTH +: BR_TYPE_WIDTH] = entryType[slotIdx];
    assign targetAddr_o[s*PC_WIDTH +: PC_WIDTH]         = entryTarget[slotIdx];
  end

  // an entry turns valid on its first update and stays valid until reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < BTB_ENTRIES; e++) begin
        entryValid[e] <= 1'b0;
      end
    end else if (updateEn_i) begin
      entryValid[updateIdx] <= 1'b1;
    end
  end

  // targets are kept bundle aligned, since fetch always starts on a bundle boundary.
  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      entryTag[updateIdx]    <= updatePC_i[PC_WIDTH-1:TAG_LSB];
      entryType[updateIdx]   <= updateBrType_i;
      entryTarget[updateIdx] <= {updateTargetAddr_i[PC_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)};
    end
  end

  // the update port comes from retired control instructions, which sit on slot boundaries.
  updatePcAligned: assert property (@(posedge clk) disable iff (reset)
    updateEn_i |-> (updatePC_i[SLOT_OFFSET_BITS-1:0] == '0));

endmodule

// ==== verilog/fetchPkg.sv ====
package fetchPkg;

  // address and instruction widths in bits.
  localparam int PC_WIDTH   = 32;
  localparam int INST_WIDTH = 64;

  // fetch geometry. a bundle holds four instructions and fills one cache line.
  localparam int FETCH_WIDTH  = 4;
  localparam int BUNDLE_WIDTH = FETCH_WIDTH * INST_WIDTH;
  localparam int SLOT_BYTES   = INST_WIDTH / 8;
  localparam int BUNDLE_BYTES = FETCH_WIDTH * SLOT_BYTES;

  // low PC bits that select a byte inside a bundle and inside a slot.
  localparam int OFFSET_BITS      = $clog2(BUNDLE_BYTES);
  localparam int SLOT_OFFSET_BITS = $clog2(SLOT_BYTES);

  // control-type codes as they are stored in the branch target buffer.
  localparam int BR_TYPE_WIDTH = 2;
  localparam logic [BR_TYPE_WIDTH-1:0] BR_RETURN = 2'b00;
  localparam logic [BR_TYPE_WIDTH-1:0] BR_CALL   = 2'b01;
  localparam logic [BR_TYPE_WIDTH-1:0] BR_JUMP   = 2'b10;
  localparam logic [BR_TYPE_WIDTH-1:0] BR_COND   = 2'b11;

  // the first bundle fetched after reset.
  localparam logic [PC_WIDTH-1:0] RESET_PC = '0;

endpackage
